/* Makefile */
SIM   = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP   = ldqTb
FLIST = flist.f
LOG   = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with $(SIM), run $(TOP) and search $(LOG) for the pass line"
	@echo "  clean  remove the build directory and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "TB PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* design/ldqConflictMatch.sv */
`timescale 1ns/1ps
`include "ldq_cfg.svh"

module ldqConflictMatch (
  input  ldqPkg::ldqAddrT loadAddr,
  input  ldqPkg::ldqAddrT storeAddr,
  output logic            hit
);

  localparam int halfBanks = `LDQ_BANKS / 2;

  logic       sameE;
  logic       sameO;
  logic       bankLow;
  logic       bankHigh;
  logic       byteOverlap;
  logic [3:0] sideHit;

  // line addresses per parity
  assign sameE = loadAddr.addrE == storeAddr.addrE;
  assign sameO = loadAddr.addrO == storeAddr.addrO;

  assign bankLow  = |(loadAddr.banks[halfBanks-1:0] & storeAddr.banks[halfBanks-1:0]);
  assign bankHigh = |(loadAddr.banks[`LDQ_BANKS-1:halfBanks] &
                      storeAddr.banks[`LDQ_BANKS-1:halfBanks]);

  assign byteOverlap = |(loadAddr.byteLow & storeAddr.byteLow);

  // side must be flagged on both accesses
  assign sideHit[0] = loadAddr.isOH & storeAddr.isOH & sameO & bankHigh;
  assign sideHit[1] = loadAddr.isOL & storeAddr.isOL & sameO & bankLow;
  assign sideHit[2] = loadAddr.isEH & storeAddr.isEH & sameE & bankHigh;
  assign sideHit[3] = loadAddr.isEL & storeAddr.isEL & sameE & bankLow;

  assign hit = (|sideHit) & byteOverlap;

endmodule

/* design/ldqEntry.sv */
`timescale 1ns/1ps
`include "ldq_cfg.svh"

module ldqEntry (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     flush,
  input  logic                     load,
  input  ldqPkg::ldqAllocT         loadAlloc,
  input  logic                     loadConfl,
  input  logic                     releaseEn,
  input  ldqPkg::ldqCheckT         checkReg,
  output logic                     valid,
  output logic                     confl,
  output logic [`LDQ_II_WIDTH-1:0] ii
);

  ldqPkg::ldqAddrT addrReg;
  logic            storeHit;
  logic            matchNow;

  ldqConflictMatch uMatch (
    .loadAddr  (addrReg),
    .storeAddr (checkReg.addr),
    .hit       (storeHit)
  );

  assign matchNow = checkReg.en & storeHit & valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= 1'b0;
      confl <= 1'b0;
    end else if (flush) begin
      valid <= 1'b0;
    end else if (load) begin
      valid <= 1'b1;
      confl <= loadConfl;
    end else begin
      if (releaseEn) begin
        valid <= 1'b0;
      end
      // sticky until the next load
      if (matchNow) begin
        confl <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      addrReg <= loadAlloc.addr;
      ii      <= loadAlloc.ii;
    end
  end

  // array only loads free entries and only releases valid ones
  assert property (@(posedge clk) disable iff (rst) !(load && releaseEn));

endmodule

/* design/ldqEntryArray.sv */
`timescale 1ns/1ps
`include "ldq_cfg.svh"

module ldqEntryArray (
  input  logic                                        clk,
  input  logic                                        rst,
  input  logic                                        except,
  input  ldqPkg::ldqAllocT                            alloc,
  input  ldqPkg::ldqRetireT                           retire,
  input  ldqPkg::ldqCheckT                            checkReg,
  output logic [`LDQ_ENTRIES-1:0]                     entryValid,
  output logic [`LDQ_ENTRIES-1:0]                     entryConfl,
  output logic [`LDQ_ENTRIES-1:0][`LDQ_II_WIDTH-1:0]  entryIi,
  output logic                                        stall
);

  localparam int cntW = $clog2(`LDQ_ENTRIES + 1);

  logic [`LDQ_ENTRIES-1:0] freeVec;
  logic [`LDQ_ENTRIES-1:0] lowestFree;
  logic [`LDQ_ENTRIES-1:0] loadVec;
  logic [`LDQ_ENTRIES-1:0] iiMatch;
  logic [`LDQ_ENTRIES-1:0] releaseVec;
  logic                    allocOk;
  logic                    allocHit;
  logic                    allocConfl;
  logic [cntW-1:0]         occ;

  assign freeVec    = ~entryValid;
  // isolate lowest set bit
  assign lowestFree = freeVec & (~freeVec + 1'b1);

  assign allocOk = alloc.en & ~stall & ~except & (|freeVec);
  assign loadVec = lowestFree & {`LDQ_ENTRIES{allocOk}};

  // store in checkReg this cycle also hits the incoming load
  ldqConflictMatch uAllocMatch (
    .loadAddr  (alloc.addr),
    .storeAddr (checkReg.addr),
    .hit       (allocHit)
  );

  assign allocConfl = checkReg.en & allocHit;

  always_comb begin
    for (int i = 0; i < `LDQ_ENTRIES; i++) begin
      iiMatch[i] = entryValid[i] && (entryIi[i] == retire.ii);
    end
  end

  assign releaseVec = iiMatch & {`LDQ_ENTRIES{retire.en}};

  for (genvar i = 0; i < `LDQ_ENTRIES; i++) begin : gEntry
    ldqEntry uEntry (
      .clk       (clk),
      .rst       (rst),
      .flush     (except),
      .load      (loadVec[i]),
      .loadAlloc (alloc),
      .loadConfl (allocConfl),
      .releaseEn (releaseVec[i]),
      .checkReg  (checkReg),
      .valid     (entryValid[i]),
      .confl     (entryConfl[i]),
      .ii        (entryIi[i])
    );
  end

  always_ff @(posedge clk) begin
    if (rst || except) begin
      occ <= '0;
    end else begin
      occ <= occ + cntW'(allocOk) - cntW'(|releaseVec);
    end
  end

  assign stall = occ >= cntW'(`LDQ_STALL_LEVEL);

  // producer honours the stall level
  assert property (@(posedge clk) disable iff (rst) alloc.en |-> !stall);

  // live ii values are unique
  assert property (@(posedge clk) disable iff (rst) retire.en |-> $onehot0(iiMatch));

endmodule

/* design/ldqPkg.sv */
`include "ldq_cfg.svh"

package ldqPkg;

  // one access as seen by the queue
  typedef struct packed {
    logic [`LDQ_LINE_WIDTH-1:0] addrE;
    logic [`LDQ_LINE_WIDTH-1:0] addrO;
    // low half is the low side, high half the high side
    logic [`LDQ_BANKS-1:0]      banks;
    logic [`LDQ_BLOW_WIDTH-1:0] byteLow;
    logic                       isOH;
    logic                       isEH;
    logic                       isOL;
    logic                       isEL;
  } ldqAddrT;

  typedef struct packed {
    logic                     en;
    ldqAddrT                  addr;
    logic [`LDQ_II_WIDTH-1:0] ii;
  } ldqAllocT;

  typedef struct packed {
    logic    en;
    ldqAddrT addr;
  } ldqCheckT;

  typedef struct packed {
    logic                     en;
    logic [`LDQ_II_WIDTH-1:0] ii;
  } ldqRetireT;

  typedef struct packed {
    logic valid;
    logic hit;
    logic confl;
  } ldqResultT;

endpackage

/* design/ldqRetireStage.sv */
`timescale 1ns/1ps
`include "ldq_cfg.svh"

module ldqRetireStage (
  input  logic                                        clk,
  input  logic                                        rst,
  input  logic                                        except,
  input  ldqPkg::ldqRetireT                           retire,
  input  logic [`LDQ_ENTRIES-1:0]                     entryValid,
  input  logic [`LDQ_ENTRIES-1:0]                     entryConfl,
  input  logic [`LDQ_ENTRIES-1:0][`LDQ_II_WIDTH-1:0]  entryIi,
  output ldqPkg::ldqResultT                           result
);

  logic [`LDQ_ENTRIES-1:0] iiHit;
  logic                    hitNow;
  logic                    conflNow;

  always_comb begin
    for (int i = 0; i < `LDQ_ENTRIES; i++) begin
      iiHit[i] = entryValid[i] && (entryIi[i] == retire.ii);
    end
  end

  // flush wins over a retire in the same cycle
  assign hitNow   = (|iiHit) & ~except;
  assign conflNow = hitNow & (|(iiHit & entryConfl));

  always_ff @(posedge clk) begin
    if (rst) begin
      result <= '0;
    end else begin
      result.valid <= retire.en;
      result.hit   <= retire.en & hitNow;
      result.confl <= retire.en & conflNow;
    end
  end

  // confl is or-reduced, so a retire may match one entry at most
  assert property (@(posedge clk) disable iff (rst) retire.en |-> $onehot0(iiHit));

endmodule

/* design/ldqStoreCheckStage.sv */
`timescale 1ns/1ps

module ldqStoreCheckStage (
  input  logic             clk,
  input  logic             rst,
  input  ldqPkg::ldqCheckT check,
  input  logic             except,
  output ldqPkg::ldqCheckT checkReg
);

  // a check caught by a flush is dropped
  always_ff @(posedge clk) begin
    if (rst || except) begin
      checkReg.en <= 1'b0;
    end else begin
      checkReg.en <= check.en;
    end
  end

  // address only moves with a real check
  always_ff @(posedge clk) begin
    if (check.en) begin
      checkReg.addr <= check.addr;
    end
  end

endmodule

/* design/ldqTop.sv */
`timescale 1ns/1ps
`include "ldq_cfg.svh"

module ldqTop (
  input  logic              clk,
  input  logic              rst,
  input  logic              except,
  input  ldqPkg::ldqAllocT  alloc,
  input  ldqPkg::ldqCheckT  check,
  input  ldqPkg::ldqRetireT retire,
  output ldqPkg::ldqResultT result,
  output logic              stall
);

  ldqPkg::ldqCheckT                           checkReg;
  logic [`LDQ_ENTRIES-1:0]                    entryValid;
  logic [`LDQ_ENTRIES-1:0]                    entryConfl;
  logic [`LDQ_ENTRIES-1:0][`LDQ_II_WIDTH-1:0] entryIi;

  ldqStoreCheckStage uCheckStage (
    .clk      (clk),
    .rst      (rst),
    .check    (check),
    .except   (except),
    .checkReg (checkReg)
  );

  ldqEntryArray uArray (
    .clk        (clk),
    .rst        (rst),
    .except     (except),
    .alloc      (alloc),
    .retire     (retire),
    .checkReg   (checkReg),
    .entryValid (entryValid),
    .entryConfl (entryConfl),
    .entryIi    (entryIi),
    .stall      (stall)
  );

  ldqRetireStage uRetireStage (
    .clk        (clk),
    .rst        (rst),
    .except     (except),
    .retire     (retire),
    .entryValid (entryValid),
    .entryConfl (entryConfl),
    .entryIi    (entryIi),
    .result     (result)
  );

endmodule

/* design/ldq_cfg.svh */
`ifndef LDQ_CFG_SVH
`define LDQ_CFG_SVH

// queue geometry
`define LDQ_ENTRIES     8
`define LDQ_II_WIDTH    10

// address fields of one access
`define LDQ_LINE_WIDTH  36
`define LDQ_BANKS       32
`define LDQ_BLOW_WIDTH  4

// occupancy at which the producer must hold off
`define LDQ_STALL_LEVEL 6

`endif

/* flist.f */
+incdir+design
design/ldqPkg.sv
design/ldqConflictMatch.sv
design/ldqStoreCheckStage.sv
design/ldqEntry.sv
design/ldqEntryArray.sv
design/ldqRetireStage.sv
design/ldqTop.sv
verification/ldqTb.sv

/* verification/ldqTb.sv */
`timescale 1ns/1ps
`include "ldq_cfg.svh"

module ldqTb;

  localparam int halfBanks = `LDQ_BANKS / 2;

  logic              clk;
  logic              rst;
  logic              except;
  ldqPkg::ldqAllocT  alloc;
  ldqPkg::ldqCheckT  check;
  ldqPkg::ldqRetireT retire;
  ldqPkg::ldqResultT result;
  logic              stall;

  // reference model of the entries
  logic [`LDQ_ENTRIES-1:0]  mValid;
  logic [`LDQ_ENTRIES-1:0]  mConfl;
  ldqPkg::ldqAddrT          mAddr [`LDQ_ENTRIES];
  logic [`LDQ_II_WIDTH-1:0] mIi [`LDQ_ENTRIES];
  logic                     mChkEn;
  ldqPkg::ldqAddrT          mChkAddr;
  int                       mOcc;
  ldqPkg::ldqResultT        expResult;

  logic [`LDQ_II_WIDTH-1:0] live [$];
  int                       errResult;
  int                       errStall;
  int                       errDirected;
  int                       errTimeout;

  ldqTop i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // four sides, each needs line, bank half and byte overlap
  function automatic logic conflictOf(ldqPkg::ldqAddrT ld, ldqPkg::ldqAddrT st);
    logic lowOv;
    logic highOv;
    logic side;
    lowOv  = |(ld.banks[halfBanks-1:0] & st.banks[halfBanks-1:0]);
    highOv = |(ld.banks[`LDQ_BANKS-1:halfBanks] & st.banks[`LDQ_BANKS-1:halfBanks]);
    side = (ld.isOH && st.isOH && ld.addrO == st.addrO && highOv) ||
           (ld.isOL && st.isOL && ld.addrO == st.addrO && lowOv) ||
           (ld.isEH && st.isEH && ld.addrE == st.addrE && highOv) ||
           (ld.isEL && st.isEL && ld.addrE == st.addrE && lowOv);
    return side && (|(ld.byteLow & st.byteLow));
  endfunction

  function automatic ldqPkg::ldqAddrT addrOf(input logic [`LDQ_LINE_WIDTH-1:0] e,
                                             input logic [`LDQ_LINE_WIDTH-1:0] o,
                                             input logic [`LDQ_BANKS-1:0] b,
                                             input logic [`LDQ_BLOW_WIDTH-1:0] bl,
                                             input logic [3:0] sides);
    ldqPkg::ldqAddrT x;
    x.addrE   = e;
    x.addrO   = o;
    x.banks   = b;
    x.byteLow = bl;
    {x.isOH, x.isEH, x.isOL, x.isEL} = sides;
    return x;
  endfunction

  // small line range so stores do hit loads
  function automatic ldqPkg::ldqAddrT randomAddr();
    return addrOf(`LDQ_LINE_WIDTH'($urandom % 3), `LDQ_LINE_WIDTH'($urandom % 3),
                  `LDQ_BANKS'($urandom & $urandom), `LDQ_BLOW_WIDTH'($urandom), 4'($urandom));
  endfunction

  function automatic logic isLive(input logic [`LDQ_II_WIDTH-1:0] ii);
    foreach (live[i]) begin
      if (live[i] == ii) return 1'b1;
    end
    return 1'b0;
  endfunction

  always @(posedge clk) begin : model
    int   hitIdx;
    int   freeIdx;
    logic allocTake;
    hitIdx  = -1;
    freeIdx = -1;
    for (int i = 0; i < `LDQ_ENTRIES; i++) begin
      if (mValid[i] && mIi[i] == retire.ii) hitIdx = i;
      if (!mValid[i] && freeIdx < 0) freeIdx = i;
    end
    if (rst) begin
      mValid    = '0;
      mConfl    = '0;
      mChkEn    = 1'b0;
      mOcc      = 0;
      expResult = '0;
    end else begin
      expResult.valid = retire.en;
      expResult.hit   = retire.en && hitIdx >= 0 && !except;
      expResult.confl = 1'b0;
      if (expResult.hit) expResult.confl = mConfl[hitIdx];
      allocTake = alloc.en && mOcc < `LDQ_STALL_LEVEL && freeIdx >= 0 && !except;
      if (except) begin
        mValid = '0;
        mOcc   = 0;
      end else begin
        for (int i = 0; i < `LDQ_ENTRIES; i++) begin
          if (mValid[i] && mChkEn && conflictOf(mAddr[i], mChkAddr)) mConfl[i] = 1'b1;
        end
        if (retire.en && hitIdx >= 0) begin
          mValid[hitIdx] = 1'b0;
          mOcc--;
        end
        if (allocTake) begin
          mValid[freeIdx] = 1'b1;
          mConfl[freeIdx] = mChkEn && conflictOf(alloc.addr, mChkAddr);
          mAddr[freeIdx]  = alloc.addr;
          mIi[freeIdx]    = alloc.ii;
          mOcc++;
        end
      end
      mChkEn = check.en && !except;
      if (check.en) mChkAddr = check.addr;
    end
  end

  always @(negedge clk) begin : compare
    if (!rst) begin
      if (result !== expResult) begin
        errResult++;
        $display("FAILED %0t: result v/h/c %b%b%b, expected %b%b%b", $time, result.valid,
                 result.hit, result.confl, expResult.valid, expResult.hit, expResult.confl);
      end
      if (stall !== (mOcc >= `LDQ_STALL_LEVEL)) begin
        errStall++;
        $display("FAILED %0t: stall %b with occupancy %0d", $time, stall, mOcc);
      end
    end
  end

  task automatic driveCycle(input ldqPkg::ldqAllocT a, input ldqPkg::ldqCheckT c,
                            input ldqPkg::ldqRetireT r, input logic ex);
    @(posedge clk);
    alloc  <= a;
    check  <= c;
    retire <= r;
    except <= ex;
  endtask

  task automatic idle(input int n);
    repeat (n) driveCycle('0, '0, '0, 1'b0);
  endtask

  task automatic awaitResult(input logic expHit, input logic expConfl, input string what);
    int   n;
    logic seen;
    idle(1);
    n    = 0;
    seen = 1'b0;
    while (!seen && n < 8) begin
      @(negedge clk);
      seen = result.valid;
      n++;
    end
    if (!seen) begin
      errTimeout++;
      $display("no retire result arrived for %s", what);
    end else if (result.hit !== expHit || result.confl !== expConfl) begin
      errDirected++;
      $display("FAILED %0t: %s gave hit %b confl %b, expected %b %b", $time, what,
               result.hit, result.confl, expHit, expConfl);
    end
  endtask

  task automatic retireExpect(input logic [`LDQ_II_WIDTH-1:0] tag, input logic expHit,
                              input logic expConfl, input string what);
    driveCycle('0, '0, '{en: 1'b1, ii: tag}, 1'b0);
    awaitResult(expHit, expConfl, what);
  endtask

  task automatic waitStall(input logic level, input string what);
    int n;
    idle(1);
    n = 0;
    @(negedge clk);
    while (stall !== level && n < 10) begin
      @(negedge clk);
      n++;
    end
    if (stall !== level) begin
      errTimeout++;
      $display("stall never reached %b after %s", level, what);
    end
  endtask

  // load, then a store check, then retire well after the check lands
  task automatic conflictCase(input ldqPkg::ldqAddrT ld, input ldqPkg::ldqAddrT st,
                              input logic [`LDQ_II_WIDTH-1:0] tag, input logic expConfl,
                              input string what);
    driveCycle('{en: 1'b1, addr: ld, ii: tag}, '0, '0, 1'b0);
    idle(1);
    driveCycle('0, '{en: 1'b1, addr: st}, '0, 1'b0);
    idle(2);
    retireExpect(tag, 1'b1, expConfl, what);
  endtask

  initial begin : watchdog
    repeat (20000) @(posedge clk);
    $display("simulation ran out of cycles before the test sequence ended");
    $display("TB FAILED");
    $finish;
  end

  initial begin : stimulus
    ldqPkg::ldqAddrT          loadA;
    ldqPkg::ldqAllocT         a;
    ldqPkg::ldqCheckT         c;
    ldqPkg::ldqRetireT        r;
    logic                     ex;
    logic [`LDQ_II_WIDTH-1:0] nextIi;
    rst    = 1'b1;
    except = 1'b0;
    alloc  = '0;
    check  = '0;
    retire = '0;
    void'($urandom(15317));
    repeat (4) @(posedge clk);
    rst <= 1'b0;

    // odd-low and even-high load
    loadA = addrOf(36'h100, 36'h101, 32'h0030_0030, 4'b0011, 4'b0110);
    driveCycle('{en: 1'b1, addr: loadA, ii: 10'd1}, '0, '0, 1'b0);
    idle(2);
    retireExpect(10'd1, 1'b1, 1'b0, "plain load");
    retireExpect(10'd500, 1'b0, 1'b0, "unknown ii");

    conflictCase(loadA, addrOf(36'h100, 36'h101, 32'h0000_0010, 4'b0001, 4'b0010),
                 10'd2, 1'b1, "odd-low match");
    conflictCase(loadA, addrOf(36'h100, 36'h101, 32'h0010_0000, 4'b0010, 4'b0100),
                 10'd3, 1'b1, "even-high match");
    conflictCase(loadA, addrOf(36'h100, 36'h201, 32'h0000_0010, 4'b0001, 4'b0010),
                 10'd4, 1'b0, "other line");
    conflictCase(loadA, addrOf(36'h100, 36'h101, 32'h0010_0000, 4'b0001, 4'b0010),
                 10'd5, 1'b0, "other bank half");
    conflictCase(loadA, addrOf(36'h100, 36'h101, 32'h0000_0010, 4'b1100, 4'b0010),
                 10'd6, 1'b0, "disjoint bytes");
    conflictCase(loadA, addrOf(36'h100, 36'h101, 32'h0030_0030, 4'b0011, 4'b1000),
                 10'd7, 1'b0, "side only in store");

    // store one edge ahead of the allocation
    driveCycle('0, '{en: 1'b1, addr: loadA}, '0, 1'b0);
    driveCycle('{en: 1'b1, addr: loadA, ii: 10'd20}, '0, '0, 1'b0);
    idle(2);
    retireExpect(10'd20, 1'b1, 1'b1, "check before allocation");

    for (int k = 0; k < `LDQ_STALL_LEVEL; k++) begin
      driveCycle('{en: 1'b1, addr: loadA, ii: `LDQ_II_WIDTH'(30 + k)}, '0, '0, 1'b0);
    end
    waitStall(1'b1, "filling the queue");
    retireExpect(10'd30, 1'b1, 1'b0, "retire at stall level");
    waitStall(1'b0, "one retire");
    for (int k = 1; k < `LDQ_STALL_LEVEL; k++) begin
      retireExpect(`LDQ_II_WIDTH'(30 + k), 1'b1, 1'b0, "drain after stall");
    end

    // fill to the stall level so the flush has to drop it
    for (int k = 0; k < `LDQ_STALL_LEVEL; k++) begin
      driveCycle('{en: 1'b1, addr: loadA, ii: `LDQ_II_WIDTH'(40 + k)}, '0, '0, 1'b0);
    end
    waitStall(1'b1, "filling before flush");
    driveCycle('0, '0, '{en: 1'b1, ii: 10'd41}, 1'b1);
    awaitResult(1'b0, 1'b0, "retire during flush");
    retireExpect(10'd40, 1'b0, 1'b0, "retire after flush");
    retireExpect(10'd43, 1'b0, 1'b0, "retire after flush");
    waitStall(1'b0, "flush");
    driveCycle('{en: 1'b1, addr: loadA, ii: 10'd50}, '0, '0, 1'b0);
    idle(2);
    retireExpect(10'd50, 1'b1, 1'b0, "allocation after flush");

    nextIi = 10'd100;
    for (int cyc = 0; cyc < 400; cyc++) begin
      a  = '0;
      c  = '0;
      r  = '0;
      ex = ($urandom % 40) == 0;
      if (live.size() > 0 && ($urandom % 3) == 0) begin
        r = '{en: 1'b1, ii: live[$urandom % live.size()]};
      end else if (($urandom % 12) == 0) begin
        r = '{en: 1'b1, ii: '1};
      end
      if (live.size() < `LDQ_STALL_LEVEL && ($urandom % 2) == 0) begin
        nextIi = nextIi + 1'b1;
        while (nextIi == '1 || isLive(nextIi)) nextIi = nextIi + 1'b1;
        a = '{en: 1'b1, addr: randomAddr(), ii: nextIi};
      end
      if (($urandom % 3) == 0) c = '{en: 1'b1, addr: randomAddr()};
      driveCycle(a, c, r, ex);
      if (ex) begin
        live.delete();
      end else begin
        for (int i = 0; i < live.size(); i++) begin
          if (r.en && live[i] == r.ii) begin
            live.delete(i);
            break;
          end
        end
        if (a.en) live.push_back(a.ii);
      end
    end
    while (live.size() > 0) begin
      r = '{en: 1'b1, ii: live.pop_front()};
      driveCycle('0, '0, r, 1'b0);
    end
    idle(4);

    $display("errors: result %0d, stall %0d, directed %0d, timeout %0d",
             errResult, errStall, errDirected, errTimeout);
    if (errResult + errStall + errDirected + errTimeout == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule
